// File: common/xfcp_pkg.sv
/*
 * Shared constants, widths, opcodes and state encodings for the UART
 * command path. Referenced by scoped name from the RTL and testbench.
 */
package xfcp_pkg;

    // Clock and serial line
    localparam int CLK_FREQ_HZ       = 125_000_000;
    localparam int UART_BAUD         = 115200;
    localparam int UART_CLKS_PER_BIT = CLK_FREQ_HZ / UART_BAUD;
    localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);

    localparam int RAM_COUNT = 3;
    localparam int RAM_DEPTH = 256;

    typedef logic [7:0]            byte_t;
    typedef logic [7:0]            ram_addr_t;
    typedef logic [31:0]           ram_data_t;
    typedef logic [1:0]            port_sel_t;
    typedef logic [2:0]            byte_idx_t;
    typedef logic [UART_CNT_W-1:0] baud_cnt_t;

    // Bit timer terminal counts
    localparam baud_cnt_t BIT_LAST = baud_cnt_t'(UART_CLKS_PER_BIT - 1);
    localparam baud_cnt_t HALF_BIT = baud_cnt_t'(UART_CLKS_PER_BIT / 2);

    localparam byte_t OP_READ       = 8'h10;
    localparam byte_t OP_READ_RESP  = 8'h11;
    localparam byte_t OP_WRITE      = 8'h12;
    localparam byte_t OP_WRITE_RESP = 8'h13;
    localparam byte_t OP_ERROR      = 8'hFE;

    // Response lengths in bytes
    localparam byte_idx_t RESP_LEN_ERROR = 3'd2;
    localparam byte_idx_t RESP_LEN_WRITE = 3'd3;
    localparam byte_idx_t RESP_LEN_READ  = 3'd7;

    typedef enum logic [2:0] {
        PS_IDLE,
        PS_COLLECT,
        PS_ACCESS,
        PS_RESPOND,
        PS_WAIT_TX
    } parser_state_e;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

// File: uart/uart_rx.sv
/*
 * 8N1 serial receiver. Emits each received byte as a one-cycle strobe,
 * taken in the middle of the stop bit.
 */
module uart_rx (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              rxd_i,
    output xfcp_pkg::byte_t   rx_byte_o,
    output logic              rx_valid_o
);

    xfcp_pkg::uart_state_e state;
    xfcp_pkg::baud_cnt_t   cnt;
    logic [2:0]            bit_idx;
    logic                  rxd_meta;
    logic                  rxd_sync;
    xfcp_pkg::byte_t       shreg;

    assign rx_byte_o = shreg;

    // Two-flop synchroniser that idles high
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state      <= xfcp_pkg::UART_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            case (state)
                xfcp_pkg::UART_IDLE: begin
                    cnt <= '0;
                    if (!rxd_sync) begin
                        state <= xfcp_pkg::UART_START;
                    end
                end
                xfcp_pkg::UART_START: begin
                    // Recheck at mid start bit to reject glitches
                    if (cnt == xfcp_pkg::HALF_BIT) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? xfcp_pkg::UART_IDLE : xfcp_pkg::UART_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                xfcp_pkg::UART_DATA: begin
                    if (cnt == xfcp_pkg::BIT_LAST) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= xfcp_pkg::UART_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == xfcp_pkg::BIT_LAST) begin
                        state      <= xfcp_pkg::UART_IDLE;
                        rx_valid_o <= rxd_sync;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == xfcp_pkg::UART_DATA && cnt == xfcp_pkg::BIT_LAST) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
    end

endmodule

// File: uart/uart_tx.sv
/*
 * 8N1 serial transmitter. A byte is taken on a four-phase request and
 * acknowledged once its stop bit has gone out.
 */
module uart_tx (
    input  logic            clk,
    input  logic            arst_n_i,
    input  xfcp_pkg::byte_t tx_byte_i,
    input  logic            tx_req_i,
    output logic            tx_ack_o,
    output logic            txd_o
);

    xfcp_pkg::uart_state_e state;
    xfcp_pkg::baud_cnt_t   cnt;
    logic [2:0]            bit_idx;
    xfcp_pkg::byte_t       shreg;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= xfcp_pkg::UART_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            txd_o    <= 1'b1;
            tx_ack_o <= 1'b0;
        end else begin
            if (state != xfcp_pkg::UART_IDLE) begin
                cnt <= (cnt == xfcp_pkg::BIT_LAST) ? '0 : cnt + 1'b1;
            end
            case (state)
                xfcp_pkg::UART_IDLE: begin
                    if (tx_ack_o) begin
                        tx_ack_o <= tx_req_i;
                    end else if (tx_req_i) begin
                        txd_o <= 1'b0;
                        state <= xfcp_pkg::UART_START;
                    end
                end
                xfcp_pkg::UART_START: begin
                    if (cnt == xfcp_pkg::BIT_LAST) begin
                        txd_o   <= shreg[0];
                        bit_idx <= '0;
                        state   <= xfcp_pkg::UART_DATA;
                    end
                end
                xfcp_pkg::UART_DATA: begin
                    if (cnt == xfcp_pkg::BIT_LAST) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            txd_o <= 1'b1;
                            state <= xfcp_pkg::UART_STOP;
                        end else begin
                            txd_o <= shreg[1];
                        end
                    end
                end
                default: begin
                    if (cnt == xfcp_pkg::BIT_LAST) begin
                        tx_ack_o <= 1'b1;
                        state    <= xfcp_pkg::UART_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == xfcp_pkg::UART_IDLE && !tx_ack_o && tx_req_i) begin
            shreg <= tx_byte_i;
        end else if (state == xfcp_pkg::UART_DATA && cnt == xfcp_pkg::BIT_LAST) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

// File: src/wb_ram_port.sv
/*
 * Single-port 256 x 32 RAM behind a four-phase request. Each request
 * performs one read or write; the read word is the value before a write.
 */
module wb_ram_port (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                req_i,
    input  logic                we_i,
    input  xfcp_pkg::ram_addr_t addr_i,
    input  xfcp_pkg::ram_data_t wdata_i,
    output logic                ack_o,
    output xfcp_pkg::ram_data_t rdata_o
);

    xfcp_pkg::ram_data_t mem [xfcp_pkg::RAM_DEPTH];
    logic                access;

    // Rising edge of the request
    assign access = req_i && !ack_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_o <= mem[addr_i];
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
        end
    end

endmodule

// File: src/xfcp_port_switch.sv
/*
 * Routes one command to a RAM port by its port number. Ports outside the
 * RAM range are answered here with an error acknowledge.
 */
module xfcp_port_switch (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  logic                                 cmd_req_i,
    input  xfcp_pkg::port_sel_t                  cmd_port_i,
    input  logic                                 cmd_we_i,
    input  xfcp_pkg::ram_addr_t                  cmd_addr_i,
    input  xfcp_pkg::ram_data_t                  cmd_wdata_i,
    output logic                                 cmd_ack_o,
    output logic                                 cmd_err_o,
    output xfcp_pkg::ram_data_t                  cmd_rdata_o,
    output logic [xfcp_pkg::RAM_COUNT-1:0]       ram_req_o,
    output xfcp_pkg::ram_addr_t                  ram_addr_o,
    output logic                                 ram_we_o,
    output xfcp_pkg::ram_data_t                  ram_wdata_o,
    input  logic [xfcp_pkg::RAM_COUNT-1:0]       ram_ack_i,
    input  xfcp_pkg::ram_data_t                  ram_rdata_i [xfcp_pkg::RAM_COUNT]
);

    xfcp_pkg::port_sel_t                 sel_q;
    logic [xfcp_pkg::RAM_COUNT-1:0]      req_onehot;
    logic [xfcp_pkg::RAM_COUNT-1:0]      sel_onehot;
    logic                                port_ok;
    xfcp_pkg::ram_data_t                 sel_rdata;

    function automatic logic [xfcp_pkg::RAM_COUNT-1:0] decode(xfcp_pkg::port_sel_t p);
        logic [xfcp_pkg::RAM_COUNT-1:0] oh;
        oh = '0;
        for (int i = 0; i < xfcp_pkg::RAM_COUNT; i++) begin
            oh[i] = (int'(p) == i);
        end
        return oh;
    endfunction

    // All zero for an out of range port
    always_comb begin
        req_onehot = decode(cmd_port_i);
        sel_onehot = decode(sel_q);
        port_ok    = |req_onehot;
        sel_rdata  = '0;
        for (int i = 0; i < xfcp_pkg::RAM_COUNT; i++) begin
            if (sel_onehot[i]) begin
                sel_rdata = ram_rdata_i[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_q     <= '0;
            ram_req_o <= '0;
            cmd_ack_o <= 1'b0;
            cmd_err_o <= 1'b0;
        end else begin
            if (cmd_req_i) begin
                sel_q <= cmd_port_i;
            end
            ram_req_o <= cmd_req_i ? req_onehot : '0;
            cmd_err_o <= cmd_req_i && !port_ok;
            cmd_ack_o <= (cmd_req_i && !port_ok) || |(ram_ack_i & sel_onehot);
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_req_i) begin
            ram_addr_o  <= cmd_addr_i;
            ram_we_o    <= cmd_we_i;
            ram_wdata_o <= cmd_wdata_i;
        end
        cmd_rdata_o <= sel_rdata;
    end

endmodule

// File: src/xfcp_cmd_parser.sv
/*
 * Request framer and response builder. Gathers port, opcode, address and
 * write data from the UART, runs one switch transaction, then sends the
 * reply a byte at a time.
 */
module xfcp_cmd_parser (
    input  logic                clk,
    input  logic                arst_n_i,
    input  xfcp_pkg::byte_t     rx_byte_i,
    input  logic                rx_valid_i,
    output xfcp_pkg::byte_t     tx_byte_o,
    output logic                tx_req_o,
    input  logic                tx_ack_i,
    output logic                cmd_req_o,
    output xfcp_pkg::port_sel_t cmd_port_o,
    output logic                cmd_we_o,
    output xfcp_pkg::ram_addr_t cmd_addr_o,
    output xfcp_pkg::ram_data_t cmd_wdata_o,
    input  logic                cmd_ack_i,
    input  logic                cmd_err_i,
    input  xfcp_pkg::ram_data_t cmd_rdata_i
);

    xfcp_pkg::parser_state_e state;
    xfcp_pkg::byte_idx_t     rx_cnt;
    xfcp_pkg::byte_idx_t     tx_idx;
    xfcp_pkg::byte_idx_t     resp_len;
    xfcp_pkg::byte_idx_t     rd_sel;
    logic                    err_q;
    logic                    we_q;
    xfcp_pkg::byte_t         port_q;
    xfcp_pkg::byte_t         status;
    xfcp_pkg::ram_addr_t     addr_q;
    xfcp_pkg::ram_data_t     wdata_q;
    xfcp_pkg::ram_data_t     rdata_q;

    // Port bytes above 3 saturate so the switch still rejects them
    assign cmd_port_o  = (port_q[7:2] != 6'd0) ? '1 : port_q[1:0];
    assign cmd_we_o    = we_q;
    assign cmd_addr_o  = addr_q;
    assign cmd_wdata_o = wdata_q;

    // Response byte selected by index
    always_comb begin
        status   = err_q ? xfcp_pkg::OP_ERROR :
                   (we_q ? xfcp_pkg::OP_WRITE_RESP : xfcp_pkg::OP_READ_RESP);
        resp_len = err_q ? xfcp_pkg::RESP_LEN_ERROR :
                   (we_q ? xfcp_pkg::RESP_LEN_WRITE : xfcp_pkg::RESP_LEN_READ);
        rd_sel   = tx_idx - 3'd3;
        case (tx_idx)
            3'd0:    tx_byte_o = port_q;
            3'd1:    tx_byte_o = status;
            3'd2:    tx_byte_o = addr_q;
            default: tx_byte_o = rdata_q[{rd_sel[1:0], 3'b000} +: 8];
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state     <= xfcp_pkg::PS_IDLE;
            rx_cnt    <= '0;
            tx_idx    <= '0;
            err_q     <= 1'b0;
            cmd_req_o <= 1'b0;
            tx_req_o  <= 1'b0;
        end else begin
            case (state)
                xfcp_pkg::PS_IDLE: begin
                    if (rx_valid_i) begin
                        rx_cnt <= 3'd1;
                        tx_idx <= '0;
                        err_q  <= 1'b0;
                        state  <= xfcp_pkg::PS_COLLECT;
                    end
                end
                xfcp_pkg::PS_COLLECT: begin
                    if (rx_valid_i) begin
                        rx_cnt <= rx_cnt + 1'b1;
                        if (rx_cnt == 3'd1 && rx_byte_i != xfcp_pkg::OP_READ &&
                                rx_byte_i != xfcp_pkg::OP_WRITE) begin
                            // Unknown opcode ends the request here
                            err_q <= 1'b1;
                            state <= xfcp_pkg::PS_RESPOND;
                        end else if ((rx_cnt == 3'd2 && !we_q) || rx_cnt == 3'd6) begin
                            cmd_req_o <= 1'b1;
                            state     <= xfcp_pkg::PS_ACCESS;
                        end
                    end
                end
                xfcp_pkg::PS_ACCESS: begin
                    if (cmd_req_o && cmd_ack_i) begin
                        cmd_req_o <= 1'b0;
                        err_q     <= cmd_err_i;
                    end else if (!cmd_req_o && !cmd_ack_i) begin
                        state <= xfcp_pkg::PS_RESPOND;
                    end
                end
                xfcp_pkg::PS_RESPOND: begin
                    tx_req_o <= 1'b1;
                    state    <= xfcp_pkg::PS_WAIT_TX;
                end
                default: begin
                    if (tx_req_o && tx_ack_i) begin
                        tx_req_o <= 1'b0;
                    end else if (!tx_req_o && !tx_ack_i) begin
                        if (tx_idx + 1'b1 == resp_len) begin
                            state <= xfcp_pkg::PS_IDLE;
                        end else begin
                            tx_idx <= tx_idx + 1'b1;
                            state  <= xfcp_pkg::PS_RESPOND;
                        end
                    end
                end
            endcase
        end
    end

    // Command fields with write data arriving LSB first
    always_ff @(posedge clk) begin
        if (rx_valid_i && state == xfcp_pkg::PS_IDLE) begin
            port_q <= rx_byte_i;
        end
        if (rx_valid_i && state == xfcp_pkg::PS_COLLECT) begin
            case (rx_cnt)
                3'd1:    we_q    <= (rx_byte_i == xfcp_pkg::OP_WRITE);
                3'd2:    addr_q  <= rx_byte_i;
                default: wdata_q <= {rx_byte_i, wdata_q[31:8]};
            endcase
        end
        if (state == xfcp_pkg::PS_ACCESS && cmd_req_o && cmd_ack_i) begin
            rdata_q <= cmd_rdata_i;
        end
    end

endmodule

// File: src/fpga_core.sv
/*
 * Top level of the UART command path. Host packets arrive on the serial
 * line and read or write words in three independent RAMs.
 */
module fpga_core (
    input  logic clk,
    input  logic arst_n_i,
    input  logic uart_rxd_i,
    output logic uart_txd_o
);

    xfcp_pkg::byte_t                 rx_byte;
    logic                            rx_valid;
    xfcp_pkg::byte_t                 tx_byte;
    logic                            tx_req;
    logic                            tx_ack;
    logic                            cmd_req;
    xfcp_pkg::port_sel_t             cmd_port;
    logic                            cmd_we;
    xfcp_pkg::ram_addr_t             cmd_addr;
    xfcp_pkg::ram_data_t             cmd_wdata;
    logic                            cmd_ack;
    logic                            cmd_err;
    xfcp_pkg::ram_data_t             cmd_rdata;
    logic [xfcp_pkg::RAM_COUNT-1:0]  ram_req;
    xfcp_pkg::ram_addr_t             ram_addr;
    logic                            ram_we;
    xfcp_pkg::ram_data_t             ram_wdata;
    logic [xfcp_pkg::RAM_COUNT-1:0]  ram_ack;
    xfcp_pkg::ram_data_t             ram_rdata [xfcp_pkg::RAM_COUNT];

    uart_rx uart_rx_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rxd_i      (uart_rxd_i),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid)
    );

    uart_tx uart_tx_inst (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .tx_byte_i (tx_byte),
        .tx_req_i  (tx_req),
        .tx_ack_o  (tx_ack),
        .txd_o     (uart_txd_o)
    );

    xfcp_cmd_parser parser_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rx_byte_i   (rx_byte),
        .rx_valid_i  (rx_valid),
        .tx_byte_o   (tx_byte),
        .tx_req_o    (tx_req),
        .tx_ack_i    (tx_ack),
        .cmd_req_o   (cmd_req),
        .cmd_port_o  (cmd_port),
        .cmd_we_o    (cmd_we),
        .cmd_addr_o  (cmd_addr),
        .cmd_wdata_o (cmd_wdata),
        .cmd_ack_i   (cmd_ack),
        .cmd_err_i   (cmd_err),
        .cmd_rdata_i (cmd_rdata)
    );

    xfcp_port_switch switch_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cmd_req_i   (cmd_req),
        .cmd_port_i  (cmd_port),
        .cmd_we_i    (cmd_we),
        .cmd_addr_i  (cmd_addr),
        .cmd_wdata_i (cmd_wdata),
        .cmd_ack_o   (cmd_ack),
        .cmd_err_o   (cmd_err),
        .cmd_rdata_o (cmd_rdata),
        .ram_req_o   (ram_req),
        .ram_addr_o  (ram_addr),
        .ram_we_o    (ram_we),
        .ram_wdata_o (ram_wdata),
        .ram_ack_i   (ram_ack),
        .ram_rdata_i (ram_rdata)
    );

    // One RAM per switch port
    for (genvar i = 0; i < xfcp_pkg::RAM_COUNT; i++) begin : g_ram
        wb_ram_port ram_inst (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .req_i    (ram_req[i]),
            .we_i     (ram_we),
            .addr_i   (ram_addr),
            .wdata_i  (ram_wdata),
            .ack_o    (ram_ack[i]),
            .rdata_o  (ram_rdata[i])
        );
    end

endmodule

// File: tb/fpga_core_checker.sv
/*
 * Handshake and line assertions, bound into the top level. Watches the
 * UART transmit, command and RAM four-phase exchanges.
 */
module fpga_core_checker (
    input logic                           clk,
    input logic                           arst_n_i,
    input logic                           tx_req_i,
    input logic                           tx_ack_i,
    input logic                           cmd_req_i,
    input logic                           cmd_ack_i,
    input logic [xfcp_pkg::RAM_COUNT-1:0] ram_req_i,
    input logic [xfcp_pkg::RAM_COUNT-1:0] ram_ack_i,
    input logic                           txd_i
);
    timeunit 1ns;
    timeprecision 1ps;

    tx_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        tx_req_i && !tx_ack_i |=> tx_req_i)
        else $error("tx_req fell before tx_ack");

    tx_ack_has_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(tx_ack_i) |-> tx_req_i)
        else $error("tx_ack rose without tx_req");

    cmd_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        cmd_req_i && !cmd_ack_i |=> cmd_req_i)
        else $error("cmd_req fell before cmd_ack");

    cmd_ack_has_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(cmd_ack_i) |-> cmd_req_i)
        else $error("cmd_ack rose without cmd_req");

    for (genvar i = 0; i < xfcp_pkg::RAM_COUNT; i++) begin : g_ram_chk
        ram_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
            ram_req_i[i] && !ram_ack_i[i] |=> ram_req_i[i])
            else $error("ram_req fell before ram_ack on port %0d", i);

        ram_ack_has_req: assert property (@(posedge clk) disable iff (!arst_n_i)
            $rose(ram_ack_i[i]) |-> ram_req_i[i])
            else $error("ram_ack rose without ram_req on port %0d", i);
    end

    ram_req_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(ram_req_i))
        else $error("more than one RAM request active");

    // Transmitter is idle whenever both handshake lines are low
    txd_idle_high: assert property (@(posedge clk) disable iff (!arst_n_i)
        !tx_req_i && !tx_ack_i |-> txd_i)
        else $error("txd low while the transmitter is idle");

endmodule

bind fpga_core fpga_core_checker checker_inst (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .tx_req_i  (tx_req),
    .tx_ack_i  (tx_ack),
    .cmd_req_i (cmd_req),
    .cmd_ack_i (cmd_ack),
    .ram_req_i (ram_req),
    .ram_ack_i (ram_ack),
    .txd_i     (uart_txd_o)
);

// File: tb/tb_fpga_core.sv
/*
 * Testbench for the UART command path. Reads request and expected response
 * fields from the stimulus file, drives serial packets into the DUT and
 * decodes the serial response for comparison.
 */
module tb_fpga_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_TESTS    = 32;
    localparam int BIT_CLKS     = xfcp_pkg::UART_CLKS_PER_BIT;
    localparam int RESET_CYCLES = 8;
    localparam logic [255:0] COMMENT_TOK = 256'h23;

    logic clk = 1'b0;
    logic arst_n_i;
    logic uart_rxd_i;
    logic uart_txd_o;

    string               t_name      [MAX_TESTS];
    xfcp_pkg::byte_t     t_port      [MAX_TESTS];
    xfcp_pkg::byte_t     t_op        [MAX_TESTS];
    xfcp_pkg::byte_t     t_addr      [MAX_TESTS];
    xfcp_pkg::ram_data_t t_wdata     [MAX_TESTS];
    xfcp_pkg::byte_t     t_exp_op    [MAX_TESTS];
    xfcp_pkg::ram_data_t t_exp_rdata [MAX_TESTS];

    int     n_tests     = 0;
    int     n_pass      = 0;
    int     n_fail      = 0;
    int     load_errors = 0;
    longint cycle_cnt   = 0;
    longint cycle_limit = 0;

    fpga_core UUT (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .uart_rxd_i (uart_rxd_i),
        .uart_txd_o (uart_txd_o)
    );

    always #5 clk = ~clk;

    // Watchdog on total run length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 64'd1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the run stalled and did not finish within %0d cycles", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic load_stimulus();
        int                  fd;
        int                  code;
        logic                done;
        logic [255:0]        tok;
        logic [1023:0]       skip_buf;
        xfcp_pkg::byte_t     port;
        xfcp_pkg::byte_t     op;
        xfcp_pkg::byte_t     addr;
        xfcp_pkg::byte_t     eop;
        xfcp_pkg::ram_data_t wdata;
        xfcp_pkg::ram_data_t erd;
        done = 1'b0;
        fd = $fopen("tb/fpga_core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/fpga_core_stimulus.txt");
            load_errors++;
            done = 1'b1;
        end
        while (!done) begin
            tok = '0;
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok == COMMENT_TOK) begin
                code = $fgets(skip_buf, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h", port, op, addr, wdata, eop, erd);
                if (code != 6 || n_tests == MAX_TESTS) begin
                    $display("stimulus line %0d is malformed or beyond the test limit", n_tests);
                    load_errors++;
                    done = 1'b1;
                end else begin
                    t_name[n_tests]      = $sformatf("%0s", tok);
                    t_port[n_tests]      = port;
                    t_op[n_tests]        = op;
                    t_addr[n_tests]      = addr;
                    t_wdata[n_tests]     = wdata;
                    t_exp_op[n_tests]    = eop;
                    t_exp_rdata[n_tests] = erd;
                    n_tests++;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    // 8N1 frame with each bit held for one bit time
    task automatic send_byte(input xfcp_pkg::byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rxd_i <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    // Returns after the middle of the stop bit plus half a bit
    task automatic recv_byte(output xfcp_pkg::byte_t b, output logic framing_ok);
        framing_ok = 1'b1;
        b = '0;
        @(negedge clk);
        while (uart_txd_o !== 1'b0) begin
            @(negedge clk);
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        if (uart_txd_o !== 1'b0) begin
            framing_ok = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            b[i] = uart_txd_o;
        end
        repeat (BIT_CLKS) @(negedge clk);
        if (uart_txd_o !== 1'b1) begin
            framing_ok = 1'b0;
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
    endtask

    task automatic record_result(input string name, input int errs);
        if (errs == 0) begin
            n_pass++;
            $display("test %0s: ok", name);
        end else begin
            n_fail++;
            $display("test %0s: %0d errors", name, errs);
        end
    endtask

    task automatic check_line_idle(input string name);
        int errs;
        errs = 0;
        for (int k = 0; k < 10 * BIT_CLKS; k++) begin
            @(negedge clk);
            if (uart_txd_o !== 1'b1 && errs == 0) begin
                $display("FAIL %0s: uart_txd_o got 0x%0h expected 0x1", name, uart_txd_o);
                errs++;
            end
        end
        record_result(name, errs);
    endtask

    task automatic run_test(input int idx);
        xfcp_pkg::byte_t req_bytes [7];
        xfcp_pkg::byte_t exp_bytes [7];
        xfcp_pkg::byte_t got;
        logic            framing_ok;
        int              req_len;
        int              exp_len;
        int              errs;
        errs = 0;
        req_bytes[0] = t_port[idx];
        req_bytes[1] = t_op[idx];
        req_bytes[2] = t_addr[idx];
        exp_bytes[0] = t_port[idx];
        exp_bytes[1] = t_exp_op[idx];
        exp_bytes[2] = t_addr[idx];
        for (int k = 0; k < 4; k++) begin
            req_bytes[3 + k] = t_wdata[idx][8 * k +: 8];
            exp_bytes[3 + k] = t_exp_rdata[idx][8 * k +: 8];
        end
        // Unknown opcodes end the request after two bytes
        if (t_op[idx] == xfcp_pkg::OP_WRITE) begin
            req_len = 7;
        end else if (t_op[idx] == xfcp_pkg::OP_READ) begin
            req_len = 3;
        end else begin
            req_len = 2;
        end
        if (t_exp_op[idx] == xfcp_pkg::OP_READ_RESP) begin
            exp_len = 7;
        end else if (t_exp_op[idx] == xfcp_pkg::OP_WRITE_RESP) begin
            exp_len = 3;
        end else begin
            exp_len = 2;
        end
        // Response may start before the last request stop bit ends
        fork
            begin
                for (int k = 0; k < req_len; k++) begin
                    send_byte(req_bytes[k]);
                end
            end
            begin
                for (int k = 0; k < exp_len; k++) begin
                    recv_byte(got, framing_ok);
                    if (!framing_ok) begin
                        $display("%0s: response byte %0d has a broken start or stop bit",
                                 t_name[idx], k);
                        errs++;
                    end
                    if (got !== exp_bytes[k]) begin
                        $display("FAIL %0s: uart_txd_o byte %0d got 0x%02h expected 0x%02h",
                                 t_name[idx], k, got, exp_bytes[k]);
                        errs++;
                    end
                end
            end
        join
        record_result(t_name[idx], errs);
    endtask

    initial begin
        arst_n_i   = 1'b0;
        uart_rxd_i = 1'b1;
        load_stimulus();
        cycle_limit = (longint'(n_tests) * 64'd14 + 64'd2) * 64'd10 * 64'(BIT_CLKS);
        cycle_limit = 64'd2 * (cycle_limit + 64'(RESET_CYCLES));
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);
        check_line_idle("idle_after_reset");
        if (load_errors == 0) begin
            for (int i = 0; i < n_tests; i++) begin
                run_test(i);
            end
            check_line_idle("idle_after_last");
        end
        $display("tests passed %0d, failed %0d, load errors %0d", n_pass, n_fail, load_errors);
        if (n_fail == 0 && load_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb/fpga_core_stimulus.txt
# Columns: name port opcode addr wdata exp_opcode exp_rdata, all fields but name in hex
# wdata is sent for writes only, exp_rdata is compared for read responses only
wr_p0_basic     00 12 10 a5a51234 13 00000000
rd_p0_basic     00 10 10 00000000 11 a5a51234
wr_p0_shared    00 12 20 11111111 13 00000000
wr_p1_shared    01 12 20 22222222 13 00000000
wr_p2_shared    02 12 20 33333333 13 00000000
rd_p0_shared    00 10 20 00000000 11 11111111
rd_p1_shared    01 10 20 00000000 11 22222222
rd_p2_shared    02 10 20 00000000 11 33333333
wr_p1_first     01 12 40 deadbeef 13 00000000
wr_p1_second    01 12 40 cafef00d 13 00000000
rd_p1_latest    01 10 40 00000000 11 cafef00d
wr_p3_bad_port  03 12 20 ffffffff fe 00000000
rd_p3_bad_port  03 10 20 00000000 fe 00000000
rd_p0_unchanged 00 10 20 00000000 11 11111111
bad_opcode      00 55 20 00000000 fe 00000000
rd_p2_after_bad 02 10 20 00000000 11 33333333
wr_p2_after_bad 02 12 80 0badf00d 13 00000000
rd_p2_new_addr  02 10 80 00000000 11 0badf00d

// File: project.f
common/xfcp_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
src/wb_ram_port.sv
src/xfcp_port_switch.sv
src/xfcp_cmd_parser.sv
src/fpga_core.sv
tb/fpga_core_checker.sv
tb/tb_fpga_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps --top-module tb_fpga_core \
    -Mdir obj_dir -o sim -f project.f
./obj_dir/sim | tee sim.log
if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
grep -q "PASS: all tests" sim.log
echo "simulation passed"
